/* Bender.yml */
package:
  name: poly_decimator

sources:
  - files:
      - source/decim_pkg.sv
      - source/delay_line.sv
      - source/polyphase_branch.sv
      - source/commutator.sv
      - source/phase_combiner.sv
      - source/poly_decimator.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/tb_poly_decimator.sv

/* compile.f */
source/decim_pkg.sv
source/delay_line.sv
source/polyphase_branch.sv
source/commutator.sv
source/phase_combiner.sv
source/poly_decimator.sv
tests/tb_clock.sv
tests/tb_poly_decimator.sv

/* source/commutator.sv */
// Wishbone classic slave front end of the decimator
// Deals written samples out to the branches, last branch first
// Serves reads of the result and status words and signals a result take

`timescale 1ns/100ps

module commutator (
  input  logic                          i_clk,           // Rising-edge clock
  input  logic                          i_rst_an,        // Async reset, active low
  input  logic                          i_wb_cyc,        // Bus cycle
  input  logic                          i_wb_stb,        // Strobe
  input  logic                          i_wb_we,         // Write enable
  input  logic [1:0]                    i_wb_adr,        // Word address
  input  logic [decim_pkg::DATA_W-1:0]  i_wb_dat,        // Write data
  output logic [decim_pkg::DATA_W-1:0]  o_wb_dat,        // Read data
  output logic                          o_wb_ack,        // One-cycle acknowledge
  output logic [decim_pkg::DATA_W-1:0]  o_sample,        // Sample to branches
  output logic [decim_pkg::N_PHASES-1:0] o_sample_ena,   // One-hot branch select
  output logic                          o_result_taken,  // Result was read
  input  logic [decim_pkg::DATA_W-1:0]  i_result,        // Held filter output
  input  logic                          i_new,           // Unread result
  input  logic                          i_overrun,       // Result lost
  input  logic                          i_filled         // History complete
);

  import decim_pkg::*;

  logic                          req;         // New access, ack not yet given
  logic                          wr_sample;   // Sample write this cycle
  logic                          rd_result;   // Result read this cycle
  logic [$clog2(N_PHASES)-1:0]   phase;       // Down-counter, branch to feed
  logic [DATA_W-1:0]             status;      // Status word

  // --------------------------------------------------------------------------
  // Bus decode
  // --------------------------------------------------------------------------
  assign req       = i_wb_cyc && i_wb_stb && !o_wb_ack;
  assign wr_sample = req &&  i_wb_we && (i_wb_adr == ADR_RESULT);
  assign rd_result = req && !i_wb_we && (i_wb_adr == ADR_RESULT);

  // Status bits, rest reads zero
  always_comb
  begin
    status             = '0;
    status[ST_NEW]     = i_new;
    status[ST_OVERRUN] = i_overrun;
    status[ST_FILLED]  = i_filled;
  end

  // --------------------------------------------------------------------------
  // Control: ack, phase counter, branch enable, take pulse
  // --------------------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_rst_an)
  begin
    if (!i_rst_an)
    begin
      o_wb_ack       <= 1'b0;
      phase          <= ($clog2(N_PHASES))'(N_PHASES-1);
      o_sample_ena   <= '0;
      o_result_taken <= 1'b0;
    end
    else
    begin
      o_wb_ack       <= req;                            // Every access, incl. status writes
      o_result_taken <= rd_result;
      o_sample_ena   <= '0;
      if (wr_sample)
      begin
        o_sample_ena[phase] <= 1'b1;
        // Wrap after branch 0, which closes the group
        phase <= (phase == '0) ? ($clog2(N_PHASES))'(N_PHASES-1) : phase - 1'b1;
      end
    end
  end

  // Sample and read data registers
  always_ff @(posedge i_clk)
  begin
    if (wr_sample)
      o_sample <= i_wb_dat;
    if (req && !i_wb_we)
      o_wb_dat <= (i_wb_adr == ADR_STATUS) ? status : i_result;  // Other addresses alias result
  end

endmodule

/* source/decim_pkg.sv */
// Shared constants for the polyphase decimating FIR filter
// Imported by every RTL module and by the testbench model
// Holds widths, phase and tap counts, bus map and the coefficient table

package decim_pkg;

  // --------------------------------------------------------------------------
  // Datapath widths
  // --------------------------------------------------------------------------
  localparam int DATA_W     = 16;        // Samples, result and bus data, signed
  localparam int COEF_W     = 12;        // Coefficients, signed
  localparam int ACC_W      = 32;        // Branch sums and total sum

  // Filter shape
  localparam int N_PHASES   = 4;         // Decimation factor = branch count
  localparam int N_TAPS_PH  = 3;         // Taps per branch, 12 in total
  localparam int COEF_SHIFT = 4;         // Arithmetic shift before clamp

  // Symmetric low-pass, small negative side lobes, h[0] first
  localparam logic signed [COEF_W-1:0] COEFS [N_PHASES*N_TAPS_PH] = '{
    -12'sd8,   -12'sd20,  12'sd40,   12'sd180,
    12'sd400,  12'sd560,  12'sd560,  12'sd400,
    12'sd180,  12'sd40,   -12'sd20,  -12'sd8
  };

  // --------------------------------------------------------------------------
  // Bus word addresses and status bits
  // --------------------------------------------------------------------------
  localparam logic [1:0] ADR_RESULT = 2'd0;  // Read result, write sample
  localparam logic [1:0] ADR_STATUS = 2'd1;  // Read-only status

  localparam int ST_NEW     = 0;         // Unread result waiting
  localparam int ST_OVERRUN = 1;         // Result overwritten before read
  localparam int ST_FILLED  = 2;         // Full history since reset

endpackage

/* source/delay_line.sv */
// Sample history of one polyphase branch
// Shifts a new sample in on each enable and exposes every stage as a tap
// o_filled rises once all stages hold written samples and stays set

`timescale 1ns/100ps

module delay_line #(
  parameter int N_STAGES = decim_pkg::N_TAPS_PH      // History depth
) (
  input  logic                                      i_clk,     // Rising-edge clock
  input  logic                                      i_rst_an,  // Async clear, active low
  input  logic                                      i_ena,     // Shift enable
  input  logic [decim_pkg::DATA_W-1:0]              i_data,    // New sample
  output logic [N_STAGES-1:0][decim_pkg::DATA_W-1:0] o_taps,   // Tap 0 is newest
  output logic                                      o_filled   // History complete
);

  import decim_pkg::*;

  // --------------------------------------------------------------------------
  // Storage
  // --------------------------------------------------------------------------
  logic [N_STAGES-1:0][DATA_W-1:0]   stages;         // Tap registers
  logic [$clog2(N_STAGES+1)-1:0]     wr_cnt;         // Samples written, saturates

  // Shift chain, cleared so the history starts from silence
  always_ff @(posedge i_clk or negedge i_rst_an)
  begin
    if (!i_rst_an)
    begin
      stages <= '0;
    end
    else if (i_ena)
    begin
      stages[0] <= i_data;                            // Newest at the head
      for (int s = 1; s < N_STAGES; s++)
      begin
        stages[s] <= stages[s-1];                     // Age by one
      end
    end
  end

  // Fill counter, stops once full
  always_ff @(posedge i_clk or negedge i_rst_an)
  begin
    if (!i_rst_an)
    begin
      wr_cnt <= '0;
    end
    else if (i_ena && !o_filled)
    begin
      wr_cnt <= wr_cnt + 1'b1;
    end
  end

  assign o_filled = (wr_cnt == N_STAGES);              // Sticky until reset
  assign o_taps   = stages;

endmodule

/* source/phase_combiner.sv */
// Output stage of the decimator
// Adds the four branch sums once per group, scales and clamps to 16 bits
// Holds the result with new and overrun flags until the host takes it

`timescale 1ns/100ps

module phase_combiner (
  input  logic                                               i_clk,          // Rising-edge clock
  input  logic                                               i_rst_an,       // Async reset
  input  logic [decim_pkg::N_PHASES-1:0][decim_pkg::ACC_W-1:0] i_sums,       // Branch sums
  input  logic                                               i_group_done,   // Branch 0 valid
  input  logic                                               i_result_taken, // Host read
  output logic [decim_pkg::DATA_W-1:0]                       o_result,       // Held output
  output logic                                               o_new,          // Unread result
  output logic                                               o_overrun       // Result lost
);

  import decim_pkg::*;

  logic signed [ACC_W-1:0] total;     // Sum over branches
  logic signed [ACC_W-1:0] scaled;    // After arithmetic shift
  logic [DATA_W-1:0]       clamped;   // Saturated to output range

  // --------------------------------------------------------------------------
  // Sum, scale, saturate
  // --------------------------------------------------------------------------
  always_comb
  begin
    total = '0;
    for (int p = 0; p < N_PHASES; p++)
    begin
      total = total + signed'(i_sums[p]);
    end
    scaled = total >>> COEF_SHIFT;                    // Keeps sign

    // In range when all bits above the output sign bit agree with it
    if ((&scaled[ACC_W-1:DATA_W-1]) || !(|scaled[ACC_W-1:DATA_W-1]))
      clamped = scaled[DATA_W-1:0];
    else if (scaled[ACC_W-1])
      clamped = {1'b1, {(DATA_W-1){1'b0}}};          // Clamp to 8000
    else
      clamped = {1'b0, {(DATA_W-1){1'b1}}};          // Clamp to 7FFF
  end

  // --------------------------------------------------------------------------
  // Result register and flags
  // --------------------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_rst_an)
  begin
    if (!i_rst_an)
    begin
      o_result  <= '0;
      o_new     <= 1'b0;
      o_overrun <= 1'b0;
    end
    else if (i_group_done)
    begin
      o_result  <= clamped;
      o_new     <= 1'b1;
      // A take in the same cycle consumed the old result, so nothing lost
      o_overrun <= !i_result_taken && (o_new || o_overrun);
    end
    else if (i_result_taken)
    begin
      o_new     <= 1'b0;                              // Both flags clear on read
      o_overrun <= 1'b0;
    end
  end

endmodule

/* source/poly_decimator.sv */
// Top level of the 12-tap polyphase decimate-by-four FIR filter
// Host writes samples and reads results over a Wishbone classic slave port
// Commutator feeds four branches, the combiner merges their sums per group

`timescale 1ns/100ps

module poly_decimator (
  input  logic                         i_clk,     // Rising-edge clock
  input  logic                         i_rst_an,  // Async reset, active low
  input  logic                         i_wb_cyc,  // Wishbone cycle
  input  logic                         i_wb_stb,  // Wishbone strobe
  input  logic                         i_wb_we,   // Write enable
  input  logic [1:0]                   i_wb_adr,  // Word address
  input  logic [decim_pkg::DATA_W-1:0] i_wb_dat,  // Write data
  output logic [decim_pkg::DATA_W-1:0] o_wb_dat,  // Read data
  output logic                         o_wb_ack   // Acknowledge
);

  import decim_pkg::*;

  // --------------------------------------------------------------------------
  // Internal nets
  // --------------------------------------------------------------------------
  logic [DATA_W-1:0]                sample;        // Shared sample bus
  logic [N_PHASES-1:0]              sample_ena;    // One-hot branch enable
  logic [N_PHASES-1:0][ACC_W-1:0]   sums;          // Branch results
  logic [N_PHASES-1:0]              sum_valid;     // Bit 0 closes a group
  logic [N_PHASES-1:0]              filled;        // Bit 0 fills last
  logic                             result_taken;
  logic [DATA_W-1:0]                result;
  logic                             res_new;
  logic                             overrun;

  commutator commutator_inst (
    .i_clk          (i_clk),
    .i_rst_an       (i_rst_an),
    .i_wb_cyc       (i_wb_cyc),
    .i_wb_stb       (i_wb_stb),
    .i_wb_we        (i_wb_we),
    .i_wb_adr       (i_wb_adr),
    .i_wb_dat       (i_wb_dat),
    .o_wb_dat       (o_wb_dat),
    .o_wb_ack       (o_wb_ack),
    .o_sample       (sample),
    .o_sample_ena   (sample_ena),
    .o_result_taken (result_taken),
    .i_result       (result),
    .i_new          (res_new),
    .i_overrun      (overrun),
    .i_filled       (filled[0])          // Branch 0 gets the group's last sample
  );

  // One branch per phase
  for (genvar p = 0; p < N_PHASES; p++)
  begin : g_branch
    polyphase_branch #(
      .PHASE (p)
    ) branch_inst (
      .i_clk       (i_clk),
      .i_rst_an    (i_rst_an),
      .i_ena       (sample_ena[p]),
      .i_sample    (sample),
      .o_sum       (sums[p]),
      .o_sum_valid (sum_valid[p]),
      .o_filled    (filled[p])
    );
  end

  phase_combiner phase_combiner_inst (
    .i_clk          (i_clk),
    .i_rst_an       (i_rst_an),
    .i_sums         (sums),
    .i_group_done   (sum_valid[0]),      // Other branches finished earlier
    .i_result_taken (result_taken),
    .o_result       (result),
    .o_new          (res_new),
    .o_overrun      (overrun)
  );

endmodule

/* source/polyphase_branch.sv */
// One polyphase sub-filter of the decimator
// Keeps its share of the input history and forms h[PHASE+4t] * tap t
// Sum is registered one edge after the shift, with a one-cycle valid pulse

`timescale 1ns/100ps

module polyphase_branch #(
  parameter int PHASE = 0                                  // Branch index
) (
  input  logic                               i_clk,        // Rising-edge clock
  input  logic                               i_rst_an,     // Async reset, active low
  input  logic                               i_ena,        // Sample for this branch
  input  logic [decim_pkg::DATA_W-1:0]       i_sample,     // Shared sample bus
  output logic signed [decim_pkg::ACC_W-1:0] o_sum,        // Branch dot product
  output logic                               o_sum_valid,  // One-cycle strobe
  output logic                               o_filled      // History complete
);

  import decim_pkg::*;

  logic [N_TAPS_PH-1:0][DATA_W-1:0] taps;         // History, tap 0 newest
  logic                             shifted;      // Delay line moved last edge
  logic signed [ACC_W-1:0]          dot;          // Combinational dot product

  // --------------------------------------------------------------------------
  // History
  // --------------------------------------------------------------------------
  delay_line #(
    .N_STAGES (N_TAPS_PH)
  ) delay_line_inst (
    .i_clk    (i_clk),
    .i_rst_an (i_rst_an),
    .i_ena    (i_ena),
    .i_data   (i_sample),
    .o_taps   (taps),
    .o_filled (o_filled)
  );

  // --------------------------------------------------------------------------
  // Multiply-accumulate
  // --------------------------------------------------------------------------
  // Every N_PHASES-th coefficient, starting at this branch's phase
  always_comb
  begin
    dot = '0;
    for (int t = 0; t < N_TAPS_PH; t++)
    begin
      dot = dot + signed'(taps[t]) * COEFS[PHASE + N_PHASES*t];
    end
  end

  // Strobe follows the shift by one edge
  always_ff @(posedge i_clk or negedge i_rst_an)
  begin
    if (!i_rst_an)
    begin
      shifted     <= 1'b0;
      o_sum_valid <= 1'b0;
    end
    else
    begin
      shifted     <= i_ena;
      o_sum_valid <= shifted;
    end
  end

  // Sum register, loaded only when fresh
  always_ff @(posedge i_clk)
  begin
    if (shifted)
      o_sum <= dot;
  end

endmodule

/* tests/tb_clock.sv */
// Clock and reset source for the decimator testbench
// Free-running clock, active-low reset released on a falling edge

`timescale 1ns/100ps

module tb_clock #(
  parameter time PERIOD     = 100,    // Clock period in ns
  parameter int  RST_CYCLES = 3       // Cycles with reset held low
) (
  output logic o_clk,
  output logic o_rst_an
);

  initial
  begin
    o_clk = 1'b0;
    forever #(PERIOD/2) o_clk = ~o_clk;
  end

  initial
  begin
    o_rst_an = 1'b0;
    repeat (RST_CYCLES) @(posedge o_clk);
    @(negedge o_clk);                           // Away from the active edge
    o_rst_an = 1'b1;
  end

endmodule

/* tests/tb_poly_decimator.sv */
// Testbench for the polyphase decimator, driven over its Wishbone port
// A 12-sample history model predicts every result read back
// Prints one line per test, a count line and the final verdict

`timescale 1ns/100ps

module tb_poly_decimator;

  import decim_pkg::*;

  localparam int N_TAPS      = N_PHASES*N_TAPS_PH;
  localparam int TIMEOUT_CYC = 100;     // Per bus access
  localparam int MAX_POLLS   = 20;      // Status reads per wait

  typedef logic [N_PHASES-1:0][DATA_W-1:0] group_t;  // Index 0 written first

  logic              clk;
  logic              rst_an;
  logic              wb_cyc;
  logic              wb_stb;
  logic              wb_we;
  logic [1:0]        wb_adr;
  logic [DATA_W-1:0] wb_dat_w;
  logic [DATA_W-1:0] wb_dat_r;
  logic              wb_ack;

  logic signed [DATA_W-1:0] hist [$];   // Newest sample at index 0
  int n_tests;
  int n_failed;
  int n_checks;
  int n_errors;
  int err_base;
  bit timed_out;

  tb_clock #(.PERIOD(100), .RST_CYCLES(3)) tb_clock_inst (.o_clk(clk), .o_rst_an(rst_an));

  poly_decimator poly_decimator_inst (
    .i_clk    (clk),
    .i_rst_an (rst_an),
    .i_wb_cyc (wb_cyc),
    .i_wb_stb (wb_stb),
    .i_wb_we  (wb_we),
    .i_wb_adr (wb_adr),
    .i_wb_dat (wb_dat_w),
    .o_wb_dat (wb_dat_r),
    .o_wb_ack (wb_ack)
  );

  // --------------------------------------------------------------------------
  // Reference model of the 12-tap FIR with shift and clamp to 16 bits
  // --------------------------------------------------------------------------
  function automatic logic [DATA_W-1:0] expected_output();
    longint acc;
    acc = 0;
    for (int k = 0; k < N_TAPS; k++)
      acc += longint'(hist[k]) * longint'(COEFS[k]);   // h[k] * x[n-k]
    acc = acc >>> COEF_SHIFT;
    if (acc > 32767)
      return 16'h7FFF;
    if (acc < -32768)
      return 16'h8000;
    return acc[DATA_W-1:0];
  endfunction

  function automatic group_t random_group();
    group_t g;
    for (int j = 0; j < N_PHASES; j++)
      g[j] = $urandom;
    return g;
  endfunction

  // --------------------------------------------------------------------------
  // Reporting
  // --------------------------------------------------------------------------
  task automatic report_timeout(input string what);
    $display("Timeout: no %s within the wait limit, stopping the stimulus", what);
    n_errors++;
    timed_out = 1'b1;                           // Later accesses are skipped
  endtask

  task automatic check_value(input string name, input logic [DATA_W-1:0] exp,
                             input logic [DATA_W-1:0] act);
    if (timed_out)
      return;
    n_checks++;
    assert (act === exp)
    else
    begin
      $display("Error: %s expected %h, got %h", name, exp, act);
      n_errors++;
    end
  endtask

  task automatic finish_test(input int num, input string name);
    n_tests++;
    if (n_errors == err_base)
      $display("Test %0d %s: ok", num, name);
    else
    begin
      n_failed++;
      $display("Test %0d %s: %0d error(s)", num, name, n_errors - err_base);
    end
    err_base = n_errors;
  endtask

  // --------------------------------------------------------------------------
  // Bus tasks that change inputs on the falling edge
  // --------------------------------------------------------------------------
  task automatic bus_access(input logic we, input logic [1:0] adr,
                            input logic [DATA_W-1:0] wdat, output logic [DATA_W-1:0] rdat);
    int cyc;
    rdat = '0;
    if (timed_out)
      return;
    @(negedge clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdat;
    cyc      = 0;
    do
    begin
      @(negedge clk);                           // Ack sampled mid-cycle
      cyc++;
    end
    while (!wb_ack && cyc < TIMEOUT_CYC);
    rdat   = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    if (!wb_ack)
      report_timeout("bus acknowledge");
  endtask

  task automatic write_sample(input logic [DATA_W-1:0] s);
    logic [DATA_W-1:0] unused;
    bus_access(1'b1, ADR_RESULT, s, unused);
    hist.push_front(s);
    void'(hist.pop_back());                     // Keep exactly N_TAPS
  endtask

  task automatic read_reg(input logic [1:0] adr, output logic [DATA_W-1:0] data);
    bus_access(1'b0, adr, '0, data);
  endtask

  // Poll status until a bit is set
  task automatic wait_status(input int bitpos, output logic [DATA_W-1:0] st);
    int polls;
    polls = 0;
    do
    begin
      read_reg(ADR_STATUS, st);
      polls++;
    end
    while (!st[bitpos] && polls < MAX_POLLS && !timed_out);
    if (!st[bitpos] && !timed_out)
      report_timeout("status flag");
  endtask

  // Four writes, wait for the result, read and compare
  task automatic check_group(input group_t g, input bit check_clear,
                             output logic [DATA_W-1:0] rd);
    logic [DATA_W-1:0] st;
    for (int j = 0; j < N_PHASES; j++)
      write_sample(g[j]);
    wait_status(ST_NEW, st);
    check_value("status.ST_OVERRUN", 16'd0, st[ST_OVERRUN]);  // Previous result was read
    read_reg(ADR_RESULT, rd);
    check_value("o_wb_dat", expected_output(), rd);
    if (check_clear)
    begin
      read_reg(ADR_STATUS, st);
      check_value("status.ST_NEW", 16'd0, st[ST_NEW]);
      check_value("status.ST_FILLED", 16'd1, st[ST_FILLED]);
    end
  endtask

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial
  begin
    logic [DATA_W-1:0] rd;
    logic [DATA_W-1:0] st;
    group_t            g;
    int                cyc;

    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    void'($urandom(82));
    for (int k = 0; k < N_TAPS; k++)
      hist.push_back('0);                       // History starts from silence

    cyc = 0;
    while (!rst_an && cyc < TIMEOUT_CYC)
    begin
      @(negedge clk);
      cyc++;
    end
    if (!rst_an)
      report_timeout("reset release");

    // Test 1 reads the reset values
    check_value("o_wb_ack", 16'd0, wb_ack);
    read_reg(ADR_STATUS, st);
    check_value("status", 16'h0000, st);
    read_reg(ADR_RESULT, rd);
    check_value("o_wb_dat", 16'h0000, rd);
    finish_test(1, "reset state");

    // Test 6 watches the fill flag and runs first to count from reset
    for (int i = 1; i <= 16; i++)
    begin
      write_sample('0);
      read_reg(ADR_STATUS, st);
      check_value("status.ST_FILLED", (i >= N_TAPS) ? 16'd1 : 16'd0, st[ST_FILLED]);
    end
    wait_status(ST_NEW, st);
    read_reg(ADR_RESULT, rd);                   // Clears the pending flags
    check_value("o_wb_dat", expected_output(), rd);
    finish_test(6, "fill flag");

    // Test 2 walks an impulse in each slot through all twelve taps
    for (int j = 0; j < N_PHASES; j++)
    begin
      g    = '0;
      g[j] = 16'd16;
      check_group(g, 1'b0, rd);
      for (int z = 0; z < N_TAPS_PH; z++)
        check_group('0, 1'b0, rd);
    end
    finish_test(2, "impulse");

    // Test 3 with random samples
    for (int i = 0; i < 40; i++)
      check_group(random_group(), 1'b1, rd);
    finish_test(3, "random");

    // Test 4 saturates both ways
    for (int i = 0; i < N_TAPS_PH; i++)
      check_group({N_PHASES{16'h7FFF}}, 1'b0, rd);
    check_value("o_wb_dat", 16'h7FFF, rd);
    for (int i = 0; i < N_TAPS_PH; i++)
      check_group({N_PHASES{16'h8000}}, 1'b0, rd);
    check_value("o_wb_dat", 16'h8000, rd);
    finish_test(4, "saturation");

    // Test 5 lands a second group on an unread result
    g = random_group();
    for (int j = 0; j < N_PHASES; j++)
      write_sample(g[j]);
    wait_status(ST_NEW, st);
    g = random_group();
    for (int j = 0; j < N_PHASES; j++)
      write_sample(g[j]);
    wait_status(ST_OVERRUN, st);
    check_value("status.ST_NEW", 16'd1, st[ST_NEW]);
    read_reg(ADR_RESULT, rd);
    check_value("o_wb_dat", expected_output(), rd);
    read_reg(ADR_STATUS, st);
    check_value("status.ST_NEW", 16'd0, st[ST_NEW]);
    check_value("status.ST_OVERRUN", 16'd0, st[ST_OVERRUN]);
    check_value("status.ST_FILLED", 16'd1, st[ST_FILLED]);  // Still set
    finish_test(5, "overrun");

    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             n_tests, n_failed, n_checks, n_errors);
    if (n_errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule
